// ==== sources.f ====
common/icache_geom_pkg.sv
common/itag_types_pkg.sv
itag/itag_memory.sv
itag/itag_lookup.sv
verilog/fetch_req_receiver.sv
verilog/req_fifo.sv
verilog/itag_top.sv
tests/tb_clk_gen.sv
tests/tb_itag_top.sv

// ==== Bender.yml ====
package:
  name: itag

sources:
  - common/icache_geom_pkg.sv
  - common/itag_types_pkg.sv
  - itag/itag_memory.sv
  - itag/itag_lookup.sv
  - verilog/fetch_req_receiver.sv
  - verilog/req_fifo.sv
  - verilog/itag_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_itag_top.sv

// ==== tests/tb_itag_top.sv ====
//##########################################################
// Testbench for the instruction tag cache top level
// Reference tag model is updated in request order
// Responses are sampled on the falling edge where outputs are stable
// Random addresses use a small tag and index pool to get hits
// A duplicate fill of a valid tag is turned into a lookup
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module tb_itag_top
    import icache_geom_pkg::*, itag_types_pkg::*;
();

    logic                     clk;
    logic                     arst_n;
    logic                     fetch_req;
    itag_req_t                fetch_data;
    logic                     fetch_ack;
    logic                     resp_valid;
    itag_resp_t               resp;

    logic [TAG_WIDTH-1:0]     m_tag   [ICACHE_N_WAY][ICACHE_DEPTH]; // Model tags
    logic                     m_valid [ICACHE_N_WAY][ICACHE_DEPTH];
    logic [WAY_IDX_WIDTH-1:0] m_victim;                  // Model round robin
    itag_resp_t               exp_q [$];                 // Expected responses in issue order
    logic [ADDR_WIDTH-1:0]    filled_q [$];              // Every filled address
    int                       n_issued = 0;
    int                       n_acks = 0;
    int                       n_cycles = 0;
    logic                     ack_prev = 1'b0;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    itag_top UUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .fetch_req_i (fetch_req),
        .fetch_data_i(fetch_data),
        .fetch_ack_o (fetch_ack),
        .resp_valid_o(resp_valid),
        .resp_o      (resp)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [ADDR_WIDTH-1:0] got,
                                   input logic [ADDR_WIDTH-1:0] exp);
        abort_run($sformatf("error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp));
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
            input logic [INDEX_WIDTH-1:0] idx, input logic [OFFSET_WIDTH-1:0] off);
        return {tag, idx, off};
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] rand_addr();
        return make_addr(TAG_WIDTH'(32'h400 + $urandom % 4), INDEX_WIDTH'($urandom % 4),
                         OFFSET_WIDTH'($urandom));       // Small pool for frequent hits
    endfunction

    // Finds the first valid model way holding the tag
    function automatic logic model_probe(input logic [ADDR_WIDTH-1:0] addr,
                                         output logic [WAY_IDX_WIDTH-1:0] way);
        logic [INDEX_WIDTH-1:0] idx;
        logic                   found;
        idx   = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        found = 1'b0;
        way   = '0;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (!found && m_valid[w][idx] && m_tag[w][idx] == addr[ADDR_WIDTH-1 -: TAG_WIDTH]) begin
                found = 1'b1;
                way   = WAY_IDX_WIDTH'(w);
            end
        end
        return found;
    endfunction

    // One four-phase transaction with the model updated at issue
    task automatic issue(input itag_op_e op, input logic [ADDR_WIDTH-1:0] addr, input int gap);
        itag_resp_t             exp;
        logic [INDEX_WIDTH-1:0] idx;
        repeat (gap) @(posedge clk);
        idx      = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        exp.op   = op;
        exp.addr = addr;
        exp.hit  = 1'b0;
        exp.way  = '0;
        case (op)
            OP_LOOKUP: exp.hit = model_probe(addr, exp.way);
            OP_FILL: begin
                exp.way                = m_victim;      // Victim echoed back
                m_tag[m_victim][idx]   = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
                m_valid[m_victim][idx] = 1'b1;
                m_victim               = m_victim + 1'b1;
                filled_q.push_back(addr);
            end
            default: begin
                foreach (m_valid[w, s]) m_valid[w][s] = 1'b0; // Flush
            end
        endcase
        exp_q.push_back(exp);
        @(posedge clk);
        fetch_req       <= 1'b1;
        fetch_data.op   <= op;
        fetch_data.addr <= addr;
        n_issued++;
        do @(negedge clk); while (!fetch_ack);           // Ack rises
        @(posedge clk);
        fetch_req <= 1'b0;
        do @(negedge clk); while (fetch_ack);            // Ack falls
    endtask

    task automatic random_step(input int gap);
        logic [ADDR_WIDTH-1:0]    a;
        logic [WAY_IDX_WIDTH-1:0] w;
        int                       r;
        a = rand_addr();
        r = $urandom % 16;
        if (r == 0) begin
            issue(OP_FLUSH, a, gap);
        end else if (r < 7 && !model_probe(a, w)) begin
            issue(OP_FILL, a, gap);
            issue(OP_LOOKUP, a, 0);                      // Same set right after fill
        end else begin
            issue(OP_LOOKUP, a, gap);
        end
    endtask

    task automatic check_response();
        itag_resp_t exp;
        if (exp_q.size() == 0) begin
            abort_run("Response arrived with no request outstanding");
        end else begin
            exp = exp_q.pop_front();
            assert (resp.op == exp.op)
                else report_mismatch("resp_o.op", ADDR_WIDTH'(resp.op), ADDR_WIDTH'(exp.op));
            assert (resp.addr == exp.addr)
                else report_mismatch("resp_o.addr", resp.addr, exp.addr);
            assert (resp.hit == exp.hit)
                else report_mismatch("resp_o.hit", ADDR_WIDTH'(resp.hit), ADDR_WIDTH'(exp.hit));
            assert (resp.way == exp.way)
                else report_mismatch("resp_o.way", ADDR_WIDTH'(resp.way), ADDR_WIDTH'(exp.way));
        end
    endtask

    // Ack counting and response checks at mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (fetch_ack && !ack_prev) begin
                n_acks++;
            end
            ack_prev = fetch_ack;
            if (resp_valid) begin
                check_response();
            end
        end
    end

    always @(posedge clk) begin
        n_cycles++;
        if (n_cycles > 20 * n_issued + 100) begin
            abort_run("Timeout, the DUT stopped acknowledging or responding");
        end
    end

    initial begin
        void'($urandom(32'h531));
        fetch_req  = 1'b0;
        fetch_data = '0;
        m_victim   = '0;
        foreach (m_valid[w, s]) m_valid[w][s] = 1'b0;
        wait (arst_n === 1'b1);
        for (int i = 0; i < 4; i++) issue(OP_LOOKUP, rand_addr(), 0); // Cold misses
        for (int i = 0; i < 4; i++) begin                // Fill then hit with the pointer wrapping to 0
            issue(OP_FILL, make_addr(TAG_WIDTH'(100 + i), INDEX_WIDTH'(i * 5 + 1), '0), 1);
            issue(OP_LOOKUP, make_addr(TAG_WIDTH'(100 + i), INDEX_WIDTH'(i * 5 + 1), '0), 0);
        end
        for (int t = 0; t < 5; t++) issue(OP_FILL, make_addr(TAG_WIDTH'(200 + t), 9, '0), 0);
        for (int t = 0; t < 5; t++) issue(OP_LOOKUP, make_addr(TAG_WIDTH'(200 + t), 9, '0), 0);
        issue(OP_LOOKUP, make_addr(TAG_WIDTH'(300), 9, '0), 0);  // Same index with another tag
        issue(OP_LOOKUP, make_addr(TAG_WIDTH'(201), 10, '0), 0); // Known tag at another index
        issue(OP_FLUSH, '0, 2);
        foreach (filled_q[i]) issue(OP_LOOKUP, filled_q[i], 0);
        for (int i = 0; i < 24; i++) random_step(0);     // Back to back
        for (int i = 0; i < 24; i++) random_step($urandom % 4);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);                       // Catch stray responses
        if (n_acks != n_issued) begin
            abort_run($sformatf("Saw %0d acks for %0d requests", n_acks, n_issued));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
//##########################################################
// Clock and reset source for the tag-side testbench
// 100 ns period, reset low over the first 4 rising edges
// Reset is released on a falling edge, away from the DUT flops
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;                      // Half period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/itag_top.sv ====
//##########################################################
// Tag side of the four-way instruction cache
// Four-phase fetch port in, one-cycle response pulse out
// Responses keep request order and cannot be stalled
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module itag_top
    import itag_types_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      fetch_req_i,
    input  wire itag_req_t fetch_data_i,
    output logic           fetch_ack_o,
    output logic           resp_valid_o,
    output itag_resp_t     resp_o
);

    logic      push;
    itag_req_t push_data;
    logic      fifo_full;
    logic      pop;
    logic      not_empty;
    itag_req_t head;

    fetch_req_receiver u_fetch_req_receiver (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_req_i (fetch_req_i),
        .fetch_data_i(fetch_data_i),
        .fetch_ack_o (fetch_ack_o),
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .push_data_o (push_data)
    );

    req_fifo u_req_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .push_data_i(push_data),
        .full_o     (fifo_full),
        .pop_i      (pop),
        .not_empty_o(not_empty),
        .head_o     (head)
    );

    itag_lookup u_itag_lookup (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .resp_valid_o(resp_valid_o),
        .resp_o      (resp_o)
    );

endmodule

`default_nettype wire

// ==== verilog/req_fifo.sv ====
//##########################################################
// Request FIFO, FIFO_DEPTH entries of itag_req_t
// Push and pop may share a cycle
// Push while full and pop while empty are ignored
// Head word valid whenever not_empty_o is high
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module req_fifo
    import icache_geom_pkg::*, itag_types_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      push_i,
    input  wire itag_req_t push_data_i,
    output logic           full_o,
    input  wire logic      pop_i,
    output logic           not_empty_o,
    output itag_req_t      head_o
);

    itag_req_t                 mem_q [FIFO_DEPTH];       // Entry storage
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_CNT_WIDTH-1:0] count_q;                  // Occupancy
    logic                      do_push;
    logic                      do_pop;

    assign full_o      = (count_q == FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];
    assign do_push     = push_i && !full_o;
    assign do_pop      = pop_i && not_empty_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + FIFO_PTR_WIDTH'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + FIFO_PTR_WIDTH'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + FIFO_CNT_WIDTH'(1);
                2'b01:   count_q <= count_q - FIFO_CNT_WIDTH'(1);
                default: count_q <= count_q;             // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_req_receiver.sv ====
//##########################################################
// Four-phase request receiver feeding the request FIFO
// fetch_req_i must already be synchronous to clk_i
// Data must stay stable while req is high
// Ack is withheld while the FIFO is full
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module fetch_req_receiver
    import itag_types_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      fetch_req_i,
    input  wire itag_req_t fetch_data_i,
    output logic           fetch_ack_o,
    input  wire logic      fifo_full_i,
    output logic           push_o,
    output itag_req_t      push_data_o
);

    typedef enum logic [1:0] {
        S_IDLE     = 2'd0,                               // Waiting for req high
        S_ACKED    = 2'd1,                               // First ack cycle
        S_WAIT_LOW = 2'd2                                // Ack held until req drops
    } rx_state_e;

    rx_state_e state_q;
    rx_state_e state_d;

    // Push once, on the edge that leaves idle
    assign push_o      = (state_q == S_IDLE) && fetch_req_i && !fifo_full_i;
    assign push_data_o = fetch_data_i;
    assign fetch_ack_o = (state_q != S_IDLE);            // Decoded from state flops

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (push_o) begin
                    state_d = S_ACKED;
                end
            end
            S_ACKED:    state_d = S_WAIT_LOW;            // Requester sees ack now
            S_WAIT_LOW: begin
                if (!fetch_req_i) begin
                    state_d = S_IDLE;                    // Ack drops next cycle
                end
            end
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== itag/itag_lookup.sv ====
//##########################################################
// Lookup controller, two-stage pipeline over the tag memory
// Pops the FIFO head in every cycle it is not empty
// Stage 0 drives the memory, stage 1 compares and responds
// Every response comes two cycles after its pop, in order
// Fill victim is round robin, no LRU
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module itag_lookup
    import icache_geom_pkg::*, itag_types_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       arst_n_i,
    input  wire logic       not_empty_i,
    input  wire itag_req_t  head_i,
    output logic            pop_o,
    output logic            resp_valid_o,
    output itag_resp_t      resp_o
);

    logic [TAG_WIDTH-1:0]                   s0_tag;
    logic [INDEX_WIDTH-1:0]                 s0_index;
    logic [ICACHE_N_WAY-1:0]                mem_req;
    logic                                   mem_we;
    logic                                   mem_flush;
    logic [ICACHE_N_WAY-1:0][TAG_WIDTH-1:0] tag_way;
    logic [ICACHE_N_WAY-1:0]                vbit_way;
    logic [WAY_IDX_WIDTH-1:0]               victim_q;    // Round-robin pointer
    logic                                   s1_valid_q;
    itag_req_t                              s1_req_q;
    logic [WAY_IDX_WIDTH-1:0]               s1_way_q;    // Victim used by a fill
    logic                                   hit;
    logic [WAY_IDX_WIDTH-1:0]               hit_way;

    assign pop_o    = not_empty_i;                       // One request per cycle
    assign s0_tag   = head_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign s0_index = head_i.addr[OFFSET_WIDTH +: INDEX_WIDTH];

    // Stage 0 decode into memory controls
    always_comb begin
        mem_req   = '0;
        mem_we    = 1'b0;
        mem_flush = 1'b0;
        if (pop_o) begin
            case (head_i.op)
                OP_LOOKUP: mem_req = '1;                 // Read every way
                OP_FILL: begin
                    mem_req = ICACHE_N_WAY'(1) << victim_q; // One-hot victim
                    mem_we  = 1'b1;
                end
                OP_FLUSH:  mem_flush = 1'b1;
                default:   mem_req = '0;                 // Unused op, no access
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            victim_q   <= '0;
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= pop_o;
            if (pop_o && head_i.op == OP_FILL) begin
                victim_q <= victim_q + WAY_IDX_WIDTH'(1); // Wraps after last way
            end
        end
    end

    // Stage 1 payload, waits for the memory read
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            s1_req_q <= head_i;
            s1_way_q <= victim_q;
        end
    end

    itag_memory u_itag_memory (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (mem_req),
        .we_i     (mem_we),
        .vbit_i   (1'b1),                                // Fills always validate
        .flush_i  (mem_flush),
        .data_i   (s0_tag),
        .addr_i   (s0_index),
        .tag_way_o(tag_way),
        .vbit_o   (vbit_way)
    );

    // Tag compare over valid ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (vbit_way[w] && tag_way[w] == s1_req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH]) begin
                hit     = 1'b1;
                hit_way = WAY_IDX_WIDTH'(w);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= s1_valid_q;                  // Single-cycle pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            resp_o.op   <= s1_req_q.op;
            resp_o.addr <= s1_req_q.addr;
            case (s1_req_q.op)
                OP_LOOKUP: begin
                    resp_o.hit <= hit;
                    resp_o.way <= hit_way;
                end
                OP_FILL: begin
                    resp_o.hit <= 1'b0;
                    resp_o.way <= s1_way_q;
                end
                default: begin                           // Flush reports nothing
                    resp_o.hit <= 1'b0;
                    resp_o.way <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== itag/itag_memory.sv ====
//##########################################################
// Behavioral tag array, one tag bank and valid vector per way
// Only ways with their req bit set are read or written
// Reads are registered, one cycle latency
// Flush has priority over any write, clears all valid bits
// Tag storage has no reset, valid bits reset asynchronously
//##########################################################

`default_nettype none
`timescale 1ns/1ps

module itag_memory
    import icache_geom_pkg::*;
(
    input  wire logic                                  clk_i,
    input  wire logic                                  arst_n_i,
    input  wire logic [ICACHE_N_WAY-1:0]               req_i,      // One bit per way
    input  wire logic                                  we_i,
    input  wire logic                                  vbit_i,     // Valid value on write
    input  wire logic                                  flush_i,
    input  wire logic [TAG_WIDTH-1:0]                  data_i,
    input  wire logic [INDEX_WIDTH-1:0]                addr_i,     // Set index
    output logic      [ICACHE_N_WAY-1:0][TAG_WIDTH-1:0] tag_way_o,
    output logic      [ICACHE_N_WAY-1:0]               vbit_o
);

    for (genvar w = 0; w < ICACHE_N_WAY; w++) begin : g_way

        logic [TAG_WIDTH-1:0]    tag_q [ICACHE_DEPTH];  // Tag bank of this way
        logic [ICACHE_DEPTH-1:0] vbit_q;                // Valid bit per set

        // Valid vector and its read register
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                vbit_q    <= '0;
                vbit_o[w] <= 1'b0;
            end else if (flush_i) begin
                vbit_q    <= '0;                        // Whole way invalid
            end else if (req_i[w]) begin
                if (we_i) begin
                    vbit_q[addr_i] <= vbit_i;
                end else begin
                    vbit_o[w] <= vbit_q[addr_i];
                end
            end
        end

        // Tag bank, masked per way
        always_ff @(posedge clk_i) begin
            if (req_i[w]) begin
                if (we_i) begin
                    tag_q[addr_i] <= data_i;
                end else begin
                    tag_way_o[w] <= tag_q[addr_i];      // Stale while not read
                end
            end
        end

    end

endmodule

`default_nettype wire

// ==== common/itag_types_pkg.sv ====
//##########################################################
// Request and response words of the tag-side interface
// Request is 34 bits, op on top of the fetch address
// Response echoes op and address, adds hit and way
// Encoding 2'b11 of the op is unused
//##########################################################

`default_nettype none

package itag_types_pkg;

    import icache_geom_pkg::*;

    // Operation carried with each fetch request
    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,                            // Read tags, report hit
        OP_FILL   = 2'd1,                            // Write tag into victim way
        OP_FLUSH  = 2'd2                             // Clear all valid bits
    } itag_op_e;

    // Fetch side to FIFO to lookup controller
    typedef struct packed {
        itag_op_e                op;
        logic [ADDR_WIDTH-1:0]   addr;
    } itag_req_t;

    // Lookup controller to outside, one word per request
    typedef struct packed {
        itag_op_e                 op;
        logic [ADDR_WIDTH-1:0]    addr;                // Echo of request address
        logic                     hit;                 // Lookups only
        logic [WAY_IDX_WIDTH-1:0] way;                 // Hit way or fill victim
    } itag_resp_t;

endpackage

`default_nettype wire

// ==== common/icache_geom_pkg.sv ====
//##########################################################
// Geometry of the four-way instruction tag cache
// Address split is tag | index | offset, tag on top
// Sets per way must stay a power of two (index is a plain slice)
// FIFO depth must stay a power of two, pointers wrap naturally
//##########################################################

`default_nettype none

package icache_geom_pkg;

    localparam int ICACHE_N_WAY   = 4;              // Ways per set
    localparam int ICACHE_DEPTH   = 64;             // Sets per way

    localparam int ADDR_WIDTH     = 32;             // Fetch address
    localparam int OFFSET_WIDTH   = 6;              // 64-byte lines
    localparam int INDEX_WIDTH    = $clog2(ICACHE_DEPTH);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH; // 20 bits

    localparam int WAY_IDX_WIDTH  = $clog2(ICACHE_N_WAY);

    // Request buffer between receiver and lookup
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1); // Needs to reach FIFO_DEPTH

endpackage

`default_nettype wire
